/* design/mpu_defs.svh */
`ifndef MPU_DEFS_SVH
`define MPU_DEFS_SVH

////////////////////
// Commit table sizing

// Rows in the in-order commit table
`define NUM_ENTRY 8

// Issue numbers wrap at 32, a multiple of the table depth
`define ISSUE_NO_WIDTH 5

////////////////////
// Execution lanes

`define NUM_LANES 4

// Latency range 1 to 15, zero is illegal
`define LAT_WIDTH 4

`endif

/* design/mpuPkg.sv */
`default_nettype none
`include "mpu_defs.svh"

package mpuPkg;

	// Sequential tag given at dispatch
	typedef logic [`ISSUE_NO_WIDTH-1:0] issueNoT;

	// Dispatch to lanes
	typedef struct packed {
		issueNoT                issueNo;  // Tag of the accepted instruction
		logic [`LAT_WIDTH-1:0]  latency;  // Cycles until the lane is done
	} issueReqT;

	// One row of the commit table
	typedef struct packed {
		logic     valid;    // Row holds an outstanding issue
		logic     commit;   // Lane has reported completion
		issueNoT  issueNo;
	} tabEntryT;

	// Lanes to commit table, one per cycle
	typedef struct packed {
		logic     valid;
		issueNoT  issueNo;
	} completionT;

endpackage

`default_nettype wire

/* design/ringBuffCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ringBuffCtrl #(
	parameter int numEntry = 8,                // Power of two
	localparam int addrWidth = $clog2(numEntry)
) (
	input  wire logic                  clock,
	input  wire logic                  reset,
	input  wire logic                  we,      // Push one entry
	input  wire logic                  re,      // Pop the head entry
	output logic [addrWidth-1:0]       wAddr,
	output logic [addrWidth-1:0]       rAddr,
	output logic                       full,
	output logic                       empty,
	output logic [addrWidth:0]         count    // Occupancy, 0 to numEntry
);

	// Pointers carry one extra wrap bit
	logic [addrWidth:0] wPtr;
	logic [addrWidth:0] rPtr;

	always_ff @(posedge clock) begin
		if (reset) begin
			wPtr <= '0;
			rPtr <= '0;
		end else begin
			if (we) begin
				wPtr <= wPtr + 1'b1;
			end
			if (re) begin
				rPtr <= rPtr + 1'b1;
			end
		end
	end

	assign wAddr = wPtr[addrWidth-1:0];
	assign rAddr = rPtr[addrWidth-1:0];

	// Same index, different lap
	assign full  = (wPtr[addrWidth] != rPtr[addrWidth]) &&
	               (wPtr[addrWidth-1:0] == rPtr[addrWidth-1:0]);
	assign empty = (wPtr == rPtr);
	assign count = wPtr - rPtr;   // Wraps correctly thanks to extra bit

	////////////////////
	// Checks

	// Caller must hold back on full
	noWriteWhenFull : assert property (@(posedge clock) disable iff (reset)
		we |-> !full);

	// Pop only what exists
	noReadWhenEmpty : assert property (@(posedge clock) disable iff (reset)
		re |-> !empty);

endmodule

`default_nettype wire

/* design/commitTable.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mpu_defs.svh"

module commitTable
	import mpuPkg::*;
(
	input  wire logic        clock,
	input  wire logic        reset,
	input  wire logic        issue,        // New row at the tail
	input  wire issueNoT     issueNo,
	input  wire completionT  completion,   // Mark a row as finished
	output logic             commitValid,  // Registered retire strobe
	output issueNoT          commitNo,
	output logic             full,
	output logic             empty
);

	localparam int idxWidth = $clog2(`NUM_ENTRY);

	tabEntryT               rows [`NUM_ENTRY];
	logic [idxWidth-1:0]    wAddr;
	logic [idxWidth-1:0]    rAddr;
	logic [idxWidth:0]      count;
	logic [idxWidth-1:0]    markIdx;
	logic                   retire;
	logic [`NUM_ENTRY-1:0]  validVec;

	// Tags are handed out in order, so low bits pick the row
	assign markIdx = completion.issueNo[idxWidth-1:0];

	// Head row ready to leave
	assign retire = rows[rAddr].valid && rows[rAddr].commit;

	////////////////////
	// Row updates

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `NUM_ENTRY; i++) begin
				rows[i].valid  <= 1'b0;
				rows[i].commit <= 1'b0;
			end
		end else begin
			if (completion.valid) begin
				rows[markIdx].commit <= 1'b1;
			end
			if (retire) begin   // Free the head
				rows[rAddr].valid  <= 1'b0;
				rows[rAddr].commit <= 1'b0;
			end
			if (issue) begin    // Tail never aliases head, stall covers full
				rows[wAddr].valid   <= 1'b1;
				rows[wAddr].commit  <= 1'b0;
				rows[wAddr].issueNo <= issueNo;
			end
		end
	end

	// Retire output stage
	always_ff @(posedge clock) begin
		if (reset) begin
			commitValid <= 1'b0;
		end else begin
			commitValid <= retire;
		end
	end

	always_ff @(posedge clock) begin
		if (retire) begin
			commitNo <= rows[rAddr].issueNo;
		end
	end

	ringBuffCtrl #(
		.numEntry (`NUM_ENTRY)
	) tabPtr (
		.clock (clock),
		.reset (reset),
		.we    (issue),
		.re    (retire),
		.wAddr (wAddr),
		.rAddr (rAddr),
		.full  (full),
		.empty (empty),
		.count (count)
	);

	always_comb begin
		for (int i = 0; i < `NUM_ENTRY; i++) begin
			validVec[i] = rows[i].valid;
		end
	end

	////////////////////
	// Checks

	// A lane may only finish an outstanding, unfinished tag
	completionHitsRow : assert property (@(posedge clock) disable iff (reset)
		completion.valid |-> rows[markIdx].valid && !rows[markIdx].commit &&
		                     (rows[markIdx].issueNo == completion.issueNo));

	// Pointer occupancy and row valid bits agree
	occupancyMatches : assert property (@(posedge clock) disable iff (reset)
		$countones(validVec) == count);

endmodule

`default_nettype wire

/* design/execLanes.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mpu_defs.svh"

module execLanes
	import mpuPkg::*;
(
	input  wire logic                   clock,
	input  wire logic                   reset,
	input  wire logic                   issue,
	input  wire logic [`NUM_LANES-1:0]  laneSel,    // One-hot target lane
	input  wire issueReqT               issueReq,
	output logic [`NUM_LANES-1:0]       laneBusy,   // Counting or waiting for grant
	output completionT                  completion
);

	logic [`NUM_LANES-1:0]  busy;
	logic [`NUM_LANES-1:0]  done;
	logic [`NUM_LANES-1:0]  grant;
	logic [`LAT_WIDTH-1:0]  laneCnt [`NUM_LANES];
	issueNoT                laneNo  [`NUM_LANES];
	issueNoT                winNo;

	////////////////////
	// Lane timers

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= '0;
			for (int i = 0; i < `NUM_LANES; i++) begin
				laneCnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `NUM_LANES; i++) begin
				if (issue && laneSel[i]) begin
					busy[i]    <= 1'b1;
					laneCnt[i] <= issueReq.latency - 1'b1;   // Load edge is the first of L
				end else if (grant[i]) begin
					busy[i] <= 1'b0;                         // Completion sent, lane free
				end else if (busy[i] && (laneCnt[i] != '0)) begin
					laneCnt[i] <= laneCnt[i] - 1'b1;
				end
			end
		end
	end

	// Tag held alongside the timer
	always_ff @(posedge clock) begin
		for (int i = 0; i < `NUM_LANES; i++) begin
			if (issue && laneSel[i]) begin
				laneNo[i] <= issueReq.issueNo;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < `NUM_LANES; i++) begin
			done[i] = busy[i] && (laneCnt[i] == '0);   // Holds until granted
		end
	end

	////////////////////
	// Completion arbiter

	// Lowest done lane wins
	assign grant = done & (~done + 1'b1);

	always_comb begin
		winNo = '0;
		for (int i = 0; i < `NUM_LANES; i++) begin
			if (grant[i]) begin
				winNo = winNo | laneNo[i];
			end
		end
	end

	assign completion = '{valid: |grant, issueNo: winNo};
	assign laneBusy   = busy;

	// Dispatch must pick an idle lane
	noLoadBusyLane : assert property (@(posedge clock) disable iff (reset)
		issue |-> ((laneSel & busy) == '0));

	// Zero would underflow the timer
	noZeroLatency : assert property (@(posedge clock) disable iff (reset)
		issue |-> (issueReq.latency != '0));

endmodule

`default_nettype wire

/* design/dispatchCtrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mpu_defs.svh"

module dispatchCtrl
	import mpuPkg::*;
(
	input  wire logic                   clock,
	input  wire logic                   reset,
	input  wire logic                   issueValid,    // Host strobe
	input  wire logic [`LAT_WIDTH-1:0]  issueLatency,
	input  wire logic                   drain,         // Level from host
	input  wire logic                   full,          // Commit table full
	input  wire logic                   empty,         // Commit table empty
	input  wire logic [`NUM_LANES-1:0]  laneBusy,
	output logic                        stall,
	output logic                        issue,         // Accepted strobe
	output issueReqT                    issueReq,
	output logic [`NUM_LANES-1:0]       laneSel,       // One-hot lowest free lane
	output issueNoT                     issueNo,       // Tag for the next accept
	output logic                        drained        // One-cycle pulse
);

	typedef enum logic [1:0] {
		sRun,
		sDrain,
		sDone
	} stateT;

	stateT                  state;
	stateT                  nextState;
	logic                   idle;
	logic [`NUM_LANES-1:0]  freeLanes;

	// Nothing outstanding anywhere
	assign idle = empty && !(|laneBusy);

	////////////////////
	// Run and drain FSM

	always_comb begin
		nextState = state;
		case (state)
			sRun: begin
				if (drain) begin
					nextState = idle ? sDone : sDrain;
				end
			end
			sDrain: begin
				if (idle) begin
					nextState = sDone;
				end
			end
			sDone: begin
				if (!drain) begin
					nextState = sRun;    // Release by host
				end
			end
			default: nextState = sRun;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state   <= sRun;
			drained <= 1'b0;
		end else begin
			state   <= nextState;
			drained <= (nextState == sDone) && (state != sDone);   // Entry pulse only
		end
	end

	// Drain request blocks issue from its first cycle
	assign stall = drain || (state != sRun) || full || (&laneBusy);
	assign issue = issueValid && !stall;

	////////////////////
	// Tag counter and lane pick

	always_ff @(posedge clock) begin
		if (reset) begin
			issueNo <= '0;
		end else if (issue) begin
			issueNo <= issueNo + 1'b1;   // Wraps at 32
		end
	end

	assign freeLanes = ~laneBusy;
	assign laneSel   = freeLanes & (~freeLanes + 1'b1);
	assign issueReq  = '{issueNo: issueNo, latency: issueLatency};

	// Host strobes only while stall is low
	noStrobeOnStall : assert property (@(posedge clock) disable iff (reset)
		issueValid |-> !stall);

endmodule

`default_nettype wire

/* design/mpuCommit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mpu_defs.svh"

module mpuCommit
	import mpuPkg::*;
(
	input  wire logic                   clock,
	input  wire logic                   reset,
	input  wire logic                   issueValid,
	input  wire logic [`LAT_WIDTH-1:0]  issueLatency,
	input  wire logic                   drain,
	output logic                        stall,
	output issueNoT                     issueNo,
	output logic                        commitValid,
	output issueNoT                     commitNo,
	output logic                        full,
	output logic                        drained
);

	logic                   issue;
	issueReqT               issueReq;
	logic [`NUM_LANES-1:0]  laneSel;
	logic [`NUM_LANES-1:0]  laneBusy;
	completionT             completion;
	logic                   empty;

	dispatchCtrl dispatch0 (
		.clock        (clock),
		.reset        (reset),
		.issueValid   (issueValid),
		.issueLatency (issueLatency),
		.drain        (drain),
		.full         (full),
		.empty        (empty),
		.laneBusy     (laneBusy),
		.stall        (stall),
		.issue        (issue),
		.issueReq     (issueReq),
		.laneSel      (laneSel),
		.issueNo      (issueNo),
		.drained      (drained)
	);

	// Out-of-order finish
	execLanes lanes0 (
		.clock      (clock),
		.reset      (reset),
		.issue      (issue),
		.laneSel    (laneSel),
		.issueReq   (issueReq),
		.laneBusy   (laneBusy),
		.completion (completion)
	);

	// In-order retire
	commitTable table0 (
		.clock       (clock),
		.reset       (reset),
		.issue       (issue),
		.issueNo     (issueNo),
		.completion  (completion),
		.commitValid (commitValid),
		.commitNo    (commitNo),
		.full        (full),
		.empty       (empty)
	);

endmodule

`default_nettype wire

/* dv/mpuCommitTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mpu_defs.svh"

module mpuCommitTb
	import mpuPkg::*;
();

	localparam int totalIssues = 40 + 12 + 8 + 36;   // Tests 2, 4, 5 and 6
	localparam int cycleLimit  = 16 + totalIssues * 17 + 300;   // Worst case plus slack

	logic                   clock;
	logic                   reset;
	logic                   issueValid;
	logic [`LAT_WIDTH-1:0]  issueLatency;
	logic                   drain;
	logic                   stall;
	issueNoT                issueNo;
	logic                   commitValid;
	issueNoT                commitNo;
	logic                   full;
	logic                   drained;

	// Reference model of outstanding tags
	issueNoT  refQ [$];
	issueNoT  headNo;          // Oldest tag not yet committed
	issueNoT  expectIssueNo;   // Next tag the DUT should hand out
	logic     refEmpty;
	logic     afterDrained;    // No accept since the last drained pulse
	logic     drainedOnce;     // Pulse already seen for this drain request
	int       issueCnt;
	int       commitCnt;
	int       drainedCnt;
	int       fullCycles;
	int       wrapCnt;
	int       cycleCnt;

	int       seed;
	int       errCount;
	int       testCount;
	int       testFails;
	int       testErrStart;
	string    testName;
	int       n;
	int       mark;

	mpuCommit dut0 (
		.clock        (clock),
		.reset        (reset),
		.issueValid   (issueValid),
		.issueLatency (issueLatency),
		.drain        (drain),
		.stall        (stall),
		.issueNo      (issueNo),
		.commitValid  (commitValid),
		.commitNo     (commitNo),
		.full         (full),
		.drained      (drained)
	);

	always #2 clock = ~clock;   // 4 ns period

	////////////////////
	// Helpers

	task automatic reportMismatch(input string sigName, input int expected, input int actual);
		$display("FAIL %0t ns: %s expected %0d, got %0d", $time, sigName, expected, actual);
		errCount++;
	endtask

	task automatic reportProblem(input string what);
		$display("ERROR %0t ns: %s", $time, what);
		errCount++;
	endtask

	// Uniform 1 to span
	function automatic logic [`LAT_WIDTH-1:0] randomLatency(input int span);
		int r;
		logic [`LAT_WIDTH-1:0] lat;
		r   = $unsigned($random(seed)) % span;
		lat = r[`LAT_WIDTH-1:0] + 1'b1;
		return lat;
	endfunction

	// Starts and ends at a falling edge
	task automatic sendIssue(input logic [`LAT_WIDTH-1:0] lat);
		while (stall) begin
			@(negedge clock);   // Host waits out back-pressure
		end
		issueValid   = 1'b1;
		issueLatency = lat;
		@(negedge clock);
		issueValid   = 1'b0;
	endtask

	// Drain request held past the pulse and then released
	task automatic runDrain(input int holdCycles);
		int drainsBefore;
		drainsBefore = drainedCnt;
		drain = 1'b1;
		while (drainedCnt == drainsBefore) begin
			@(negedge clock);
		end
		repeat (holdCycles) @(negedge clock);
		drain = 1'b0;
		@(negedge clock);
		while (stall) begin
			@(negedge clock);
		end
	endtask

	task automatic startTest(input string name);
		testName     = name;
		testErrStart = errCount;
	endtask

	task automatic endTest();
		testCount++;
		if (errCount == testErrStart) begin
			$display("Test %0d (%s): ok", testCount, testName);
		end else begin
			testFails++;
			$display("Test %0d (%s): %0d check(s) failed", testCount, testName,
				errCount - testErrStart);
		end
	endtask

	////////////////////
	// Reference tracking

	always @(posedge clock) begin
		if (reset) begin
			refQ.delete();
			headNo        <= '0;
			refEmpty      <= 1'b1;
			expectIssueNo <= '0;
			afterDrained  <= 1'b0;
			drainedOnce   <= 1'b0;
			issueCnt      <= 0;
			commitCnt     <= 0;
			drainedCnt    <= 0;
			fullCycles    <= 0;
			wrapCnt       <= 0;
		end else begin
			if (commitValid) begin
				commitCnt <= commitCnt + 1;
				if (refQ.size() != 0) begin
					void'(refQ.pop_front());   // Head leaves first
				end
			end
			if (issueValid && !stall) begin   // Accepted strobe
				refQ.push_back(expectIssueNo);
				issueCnt      <= issueCnt + 1;
				expectIssueNo <= expectIssueNo + 1'b1;
				afterDrained  <= 1'b0;
				if (issueNo == '1) begin
					wrapCnt <= wrapCnt + 1;   // 31 to 0 next
				end
			end
			if (drained) begin
				drainedCnt   <= drainedCnt + 1;
				afterDrained <= 1'b1;
				drainedOnce  <= 1'b1;
			end
			if (!drain) begin
				drainedOnce <= 1'b0;
			end
			if (full) begin
				fullCycles <= fullCycles + 1;
			end
			headNo   <= (refQ.size() != 0) ? refQ[0] : '0;
			refEmpty <= (refQ.size() == 0);
		end
	end

	////////////////////
	// Checks

	commitInOrder : assert property (@(posedge clock) disable iff (reset)
		commitValid |-> (!refEmpty && (commitNo == headNo)))
		else begin
			if (refEmpty) begin
				reportProblem("commit seen with nothing outstanding");
			end else begin
				reportMismatch("commitNo", int'(headNo), int'(commitNo));
			end
		end

	issueNoTracks : assert property (@(posedge clock) disable iff (reset)
		issueNo == expectIssueNo)
		else reportMismatch("issueNo", int'(expectIssueNo), int'(issueNo));

	strobeOnlyWhenReady : assert property (@(posedge clock) disable iff (reset)
		issueValid |-> !stall)
		else reportProblem("issue strobe given while stall was high");

	stallCoversFull : assert property (@(posedge clock) disable iff (reset)
		full |-> stall)
		else reportMismatch("stall", 1, int'(stall));

	stallDuringDrain : assert property (@(posedge clock) disable iff (reset)
		drain |-> stall)
		else reportMismatch("stall", 1, int'(stall));

	drainedWhenEmpty : assert property (@(posedge clock) disable iff (reset)
		drained |-> refEmpty)
		else reportProblem("drained pulsed while commits were still pending");

	quietAfterDrained : assert property (@(posedge clock) disable iff (reset)
		commitValid |-> !afterDrained)
		else reportProblem("commit came out after drained with no new issue");

	drainedOncePerRequest : assert property (@(posedge clock) disable iff (reset)
		drained |-> !drainedOnce)
		else reportProblem("drained pulsed twice for one drain request");

	// Hang guard
	always @(posedge clock) begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= cycleLimit) begin
			$display("ERROR: run did not finish within %0d cycles", cycleLimit);
			$display("Some tests failed");
			$finish;
		end
	end

	////////////////////
	// Stimulus

	initial begin
		seed         = 32'h94cf_bfcf;
		clock        = 1'b0;
		reset        = 1'b1;
		issueValid   = 1'b0;
		issueLatency = '0;
		drain        = 1'b0;
		errCount     = 0;
		testCount    = 0;
		testFails    = 0;
		repeat (16) @(negedge clock);
		reset = 1'b0;

		startTest("reset state");
		assert (stall == 1'b0) else reportMismatch("stall", 0, int'(stall));
		assert (commitValid == 1'b0) else reportMismatch("commitValid", 0, int'(commitValid));
		assert (full == 1'b0) else reportMismatch("full", 0, int'(full));
		assert (drained == 1'b0) else reportMismatch("drained", 0, int'(drained));
		assert (issueNo == '0) else reportMismatch("issueNo", 0, int'(issueNo));
		endTest();

		startTest("random latency order");
		for (n = 0; n < 40; n++) begin
			sendIssue(randomLatency(15));
		end
		endTest();

		// Everything from test 2 must retire before the pulse
		startTest("drain after random run");
		runDrain(3);
		assert (commitCnt == issueCnt) else reportMismatch("commit count", issueCnt, commitCnt);
		endTest();

		startTest("table fill and back-pressure");
		mark = fullCycles;
		sendIssue(4'd15);   // Blocks the head
		for (n = 0; n < 11; n++) begin
			sendIssue(randomLatency(2));
		end
		runDrain(2);
		assert (fullCycles != mark) else reportProblem("full never rose with 8 outstanding");
		assert (commitCnt == issueCnt) else reportMismatch("commit count", issueCnt, commitCnt);
		endTest();

		startTest("drain hold and release");
		mark = drainedCnt;
		for (n = 0; n < 8; n++) begin
			sendIssue(randomLatency(15));
		end
		runDrain(10);   // Long hold with stall high
		assert (drainedCnt == mark + 1) else reportMismatch("drained pulses", 1, drainedCnt - mark);
		endTest();

		startTest("issue number wrap");
		mark = wrapCnt;
		for (n = 0; n < 36; n++) begin
			sendIssue(randomLatency(15));
		end
		runDrain(2);
		assert (wrapCnt != mark) else reportProblem("issueNo never wrapped from 31 to 0");
		assert (commitCnt == issueCnt) else reportMismatch("commit count", issueCnt, commitCnt);
		endTest();

		$display("Tests run: %0d, tests failed: %0d, check failures: %0d",
			testCount, testFails, errCount);
		if (errCount == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* mpuCommit.f */
+incdir+design
design/mpuPkg.sv
design/ringBuffCtrl.sv
design/commitTable.sv
design/execLanes.sv
design/dispatchCtrl.sv
design/mpuCommit.sv
dv/mpuCommitTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = mpuCommitTb
FILELIST = mpuCommit.f
PASSMSG  = All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(TOOL) and run $(TOP)"
	@echo "  clean  remove the build directory"

# Status follows the search for the pass line
test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf obj_dir
